// File: rtl/keypad_config.svh
`ifndef KEYPAD_CONFIG_SVH
`define KEYPAD_CONFIG_SVH

// lines carry digits 1..9, then 0, star and hash
`define KEY_LINES 12

`define NUM_DIGITS 8

// cycles a line pattern must hold before it counts
`define DEBOUNCE_CYCLES 4

`define REFRESH_DIV 4 // clocks per digit

`endif

// File: rtl/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    `include "keypad_config.svh"

    typedef enum logic [3:0] {
        KEY_0    = 4'd0,
        KEY_1    = 4'd1,
        KEY_2    = 4'd2,
        KEY_3    = 4'd3,
        KEY_4    = 4'd4,
        KEY_5    = 4'd5,
        KEY_6    = 4'd6,
        KEY_7    = 4'd7,
        KEY_8    = 4'd8,
        KEY_9    = 4'd9,
        KEY_STAR = 4'd10,
        KEY_HASH = 4'd11
    } key_code_e;

    typedef struct packed {
        logic      valid;
        key_code_e code;
    } key_event_t;

    typedef logic [6:0] seg_pattern_t; // segments a..g with a on top

    typedef seg_pattern_t [`NUM_DIGITS-1:0] display_frame_t;

    typedef logic [$clog2(`NUM_DIGITS)-1:0] digit_index_t;

    function automatic seg_pattern_t seg_of_digit(input key_code_e code);
        case (code)
            KEY_0:   return 7'b1111110;
            KEY_1:   return 7'b0110000;
            KEY_2:   return 7'b1101101;
            KEY_3:   return 7'b1111001;
            KEY_4:   return 7'b0110011;
            KEY_5:   return 7'b1011011;
            KEY_6:   return 7'b1011111;
            KEY_7:   return 7'b1110010;
            KEY_8:   return 7'b1111111;
            KEY_9:   return 7'b1111011;
            default: return 7'b0000000; // blank
        endcase
    endfunction

endpackage

`default_nettype wire

// File: rtl/keypad_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_config.svh"

module keypad_scan import keypad_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`KEY_LINES-1:0] key_lines,
    output key_event_t            key_event
);

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

    logic [`KEY_LINES-1:0] last_lines;
    logic [CNT_W-1:0]      stable_cnt;
    logic                  armed;
    logic                  stable;
    logic                  single_key;
    logic                  fire;
    logic [3:0]            hot_idx;
    key_code_e             hot_code;

    assign stable     = (stable_cnt == CNT_W'(`DEBOUNCE_CYCLES));
    assign single_key = (last_lines != '0) &&
                        ((last_lines & (last_lines - 1'b1)) == '0);
    assign fire       = stable && single_key && armed;

    // position of the set line
    always_comb begin
        hot_idx = '0;
        for (int i = 0; i < `KEY_LINES; i++) begin
            if (last_lines[i]) begin
                hot_idx = 4'(i);
            end
        end
    end

    always_comb begin
        case (hot_idx)
            4'd9:    hot_code = KEY_0;
            4'd10:   hot_code = KEY_STAR;
            4'd11:   hot_code = KEY_HASH;
            default: hot_code = key_code_e'(hot_idx + 4'd1); // lines 0..8 are 1..9
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_lines <= '0;
            stable_cnt <= '0;
            armed      <= 1'b1;
            key_event  <= '0;
        end else begin
            if (key_lines != last_lines) begin
                last_lines <= key_lines;
                stable_cnt <= CNT_W'(1);
            end else if (!stable) begin
                stable_cnt <= stable_cnt + 1'b1; // saturates at threshold
            end

            if (fire) begin
                armed <= 1'b0;
            end else if (stable && last_lines == '0) begin
                armed <= 1'b1; // released long enough
            end

            key_event.valid <= fire;
            key_event.code  <= hot_code;
        end
    end

    // a held key must never repeat on the next cycle
    assert property (@(posedge clk) disable iff (rst)
        key_event.valid |=> !key_event.valid);

endmodule

`default_nettype wire

// File: rtl/digit_entry.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_config.svh"

module digit_entry import keypad_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  key_event_t     key_event,
    output display_frame_t edit_frame,
    output logic           commit
);

    localparam digit_index_t LAST_DIGIT = digit_index_t'(`NUM_DIGITS - 1);

    digit_index_t cursor;
    digit_index_t cursor_inc;
    seg_pattern_t new_pattern;

    assign cursor_inc  = (cursor == LAST_DIGIT) ? '0 : cursor + 1'b1;
    assign new_pattern = seg_of_digit(key_event.code);

    always_ff @(posedge clk) begin
        if (rst) begin
            cursor     <= '0;
            commit     <= 1'b0;
            edit_frame <= '0; // all digits blank
        end else begin
            commit <= 1'b0;
            if (key_event.valid) begin
                case (key_event.code)
                    KEY_HASH: begin
                        cursor <= cursor_inc;
                    end
                    KEY_STAR: begin
                        commit <= 1'b1;
                        cursor <= '0; // buffer kept for further edits
                    end
                    default: begin
                        edit_frame[cursor] <= new_pattern; // cursor stays put
                    end
                endcase
            end
        end
    end

    // events are isolated, so commit is a lone pulse
    assert property (@(posedge clk) disable iff (rst)
        commit |=> !commit);

endmodule

`default_nettype wire

// File: rtl/segment_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_config.svh"

module segment_scanner import keypad_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  display_frame_t         edit_frame,
    input  logic                   commit,
    output seg_pattern_t           seg,
    output logic [`NUM_DIGITS-1:0] digit_en
);

    localparam int PRE_W = $clog2(`REFRESH_DIV + 1);
    localparam digit_index_t LAST_DIGIT = digit_index_t'(`NUM_DIGITS - 1);

    display_frame_t   shown;
    display_frame_t   shown_next;
    logic [PRE_W-1:0] pre_cnt;
    logic             pre_wrap;
    digit_index_t     idx;
    digit_index_t     idx_next;

    assign pre_wrap   = (pre_cnt == PRE_W'(`REFRESH_DIV - 1));
    assign shown_next = commit ? edit_frame : shown;

    always_comb begin
        idx_next = idx;
        if (pre_wrap) begin
            idx_next = (idx == LAST_DIGIT) ? '0 : idx + 1'b1;
        end
    end

    assign digit_en = `NUM_DIGITS'(1) << idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            shown   <= '0;
            pre_cnt <= '0;
            idx     <= '0;
            seg     <= '0;
        end else begin
            shown   <= shown_next;
            pre_cnt <= pre_wrap ? '0 : pre_cnt + 1'b1;
            idx     <= idx_next;
            // taken from the next frame so seg tracks shown without lag
            seg     <= shown_next[idx_next];
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot(digit_en));

endmodule

`default_nettype wire

// File: rtl/keypad_display_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_config.svh"

module keypad_display_top import keypad_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`KEY_LINES-1:0]  key_lines,
    output seg_pattern_t           seg,
    output logic [`NUM_DIGITS-1:0] digit_en,
    output logic                   updated
);

    key_event_t     key_event;
    display_frame_t edit_frame;

    keypad_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .key_lines (key_lines),
        .key_event (key_event)
    );

    // commit doubles as the updated strobe
    digit_entry u_entry (
        .clk        (clk),
        .rst        (rst),
        .key_event  (key_event),
        .edit_frame (edit_frame),
        .commit     (updated)
    );

    segment_scanner u_display (
        .clk        (clk),
        .rst        (rst),
        .edit_frame (edit_frame),
        .commit     (updated),
        .seg        (seg),
        .digit_en   (digit_en)
    );

endmodule

`default_nettype wire

// File: sim/tb_keypad_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_config.svh"

module tb_keypad_display import keypad_pkg::*; ();

    localparam int PRESS_HOLD     = 2 * `DEBOUNCE_CYCLES;
    localparam int PRESS_CYCLES   = 2 * PRESS_HOLD;
    localparam int ROUND          = `REFRESH_DIV * `NUM_DIGITS;
    localparam int PRESSES        = 80;
    localparam int TIMEOUT_CYCLES = 4 * (PRESSES * PRESS_CYCLES + 8 * ROUND) + 100;

    logic                   clk;
    logic                   rst;
    logic [`KEY_LINES-1:0]  key_lines;
    seg_pattern_t           seg;
    logic [`NUM_DIGITS-1:0] digit_en;
    logic                   updated;

    display_frame_t edit_model;
    display_frame_t shown_model;
    digit_index_t   cursor_model;
    logic [31:0]    lcg_state = 32'h479d;
    int             checks = 0;
    int             errors = 0;

    keypad_display_top uut (
        .clk       (clk),
        .rst       (rst),
        .key_lines (key_lines),
        .seg       (seg),
        .digit_en  (digit_en),
        .updated   (updated)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`KEY_LINES-1:0] line_of(input key_code_e code);
        case (code)
            KEY_0:    return `KEY_LINES'(1) << 9;
            KEY_STAR: return `KEY_LINES'(1) << 10;
            KEY_HASH: return `KEY_LINES'(1) << 11;
            default:  return `KEY_LINES'(1) << (int'(code) - 1); // digits 1..9 on lines 0..8
        endcase
    endfunction

    task automatic check_pattern(input string name, input seg_pattern_t expected,
                                 input seg_pattern_t got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED %s expected %h got %h", name, expected, got);
        end
    endtask

    task automatic check_enable(input string name, input logic [`NUM_DIGITS-1:0] expected,
                                input logic [`NUM_DIGITS-1:0] got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED %s expected %h got %h", name, expected, got);
        end
    endtask

    task automatic check_strobe(input string name, input logic expected, input logic got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED %s expected %h got %h", name, expected, got);
        end
    endtask

    task automatic apply_model(input key_code_e code);
        case (code)
            KEY_HASH: cursor_model = digit_index_t'((cursor_model + 1) % `NUM_DIGITS);
            KEY_STAR: begin
                shown_model  = edit_model;
                cursor_model = '0;
            end
            default:  edit_model[cursor_model] = seg_of_digit(code);
        endcase
    endtask

    // drive a line pattern, then all zero, counting updated pulses
    task automatic hold_lines(input logic [`KEY_LINES-1:0] lines, input int hold,
                              input int gap, output int pulses);
        pulses = 0;
        @(posedge clk);
        key_lines <= lines;
        repeat (hold) begin
            @(posedge clk);
            if (updated) pulses++;
        end
        key_lines <= '0;
        repeat (gap) begin
            @(posedge clk);
            if (updated) pulses++;
        end
    endtask

    task automatic press_key(input key_code_e code);
        int pulses;
        hold_lines(line_of(code), PRESS_HOLD, PRESS_HOLD, pulses);
        apply_model(code);
        check_strobe("updated", code == KEY_STAR, pulses > 0);
        if (pulses > 1) begin
            errors++;
            $display("updated pulsed %0d times for a single press", pulses);
        end
    endtask

    task automatic verify_frame();
        logic [`NUM_DIGITS-1:0] want;
        int waited;
        for (int p = 0; p < `NUM_DIGITS; p++) begin
            want   = `NUM_DIGITS'(1) << p;
            waited = 0;
            @(negedge clk);
            while (digit_en !== want && waited < 2 * ROUND) begin
                @(negedge clk);
                waited++;
            end
            if (digit_en !== want) begin
                errors++;
                $display("digit %0d was never enabled by the scanner", p);
            end else begin
                check_pattern($sformatf("seg[%0d]", p), shown_model[p], seg);
            end
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_enable("digit_en", `NUM_DIGITS'(1), digit_en);
        repeat (4) begin
            check_strobe("updated", 1'b0, updated);
            @(negedge clk);
        end
        verify_frame(); // model is all blank
    endtask

    task automatic test_entry_commit();
        int offset;
        offset = (lcg_next() >> 16) % 10;
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < `NUM_DIGITS; i++) begin
                press_key(key_code_e'((offset + r * `NUM_DIGITS + i) % 10)); // all ten codes
                press_key(KEY_HASH);
            end
            press_key(KEY_STAR);
            verify_frame();
        end
    endtask

    task automatic test_hidden_edits();
        for (int i = 0; i < 3; i++) begin
            press_key(key_code_e'((lcg_next() >> 16) % 10));
            press_key(KEY_HASH);
        end
        verify_frame(); // still the old frame
        press_key(KEY_STAR);
        verify_frame();
        press_key(key_code_e'((lcg_next() >> 16) % 10)); // lands in slot 0
        press_key(KEY_STAR);
        verify_frame();
    endtask

    task automatic test_ignored_presses();
        int pulses;
        hold_lines(line_of(KEY_3) | line_of(KEY_7), PRESS_HOLD, PRESS_HOLD, pulses);
        check_strobe("updated", 1'b0, pulses > 0);
        press_key(KEY_STAR);
        verify_frame();
        hold_lines(line_of(KEY_8), `DEBOUNCE_CYCLES - 1, PRESS_HOLD, pulses);
        check_strobe("updated", 1'b0, pulses > 0);
        press_key(KEY_STAR);
        verify_frame();
        hold_lines(line_of(KEY_HASH), 6 * `DEBOUNCE_CYCLES, PRESS_HOLD, pulses);
        check_strobe("updated", 1'b0, pulses > 0);
        apply_model(KEY_HASH); // one step only
        press_key(KEY_4);
        press_key(KEY_STAR);
        verify_frame();
    endtask

    task automatic test_cursor_wrap();
        repeat (`NUM_DIGITS + 1) press_key(KEY_HASH);
        press_key(KEY_2); // slot 1
        press_key(KEY_STAR);
        verify_frame();
    endtask

    task automatic test_scan_order();
        int waited;
        waited = 0;
        @(negedge clk);
        while (digit_en !== `NUM_DIGITS'(1) << (`NUM_DIGITS - 1) && waited < 2 * ROUND) begin
            @(negedge clk);
            waited++;
        end
        while (digit_en !== `NUM_DIGITS'(1) && waited < 4 * ROUND) begin
            @(negedge clk);
            waited++;
        end
        if (digit_en !== `NUM_DIGITS'(1)) begin
            errors++;
            $display("scanner never returned to digit 0");
        end else begin
            for (int i = 0; i < 2 * ROUND; i++) begin
                check_enable("digit_en", `NUM_DIGITS'(1) << ((i / `REFRESH_DIV) % `NUM_DIGITS),
                             digit_en);
                @(negedge clk);
            end
        end
    endtask

    initial begin
        rst          = 1'b1;
        key_lines    = '0;
        edit_model   = '0;
        shown_model  = '0;
        cursor_model = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_entry_commit();
        test_hidden_edits();
        test_ignored_presses();
        test_cursor_wrap();
        test_scan_order();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+rtl
rtl/keypad_pkg.sv
rtl/keypad_scan.sv
rtl/digit_entry.sv
rtl/segment_scanner.sv
rtl/keypad_display_top.sv
sim/tb_keypad_display.sv
